/* Makefile */
# Verilator simulation of the fetch front end

VERILATOR ?= verilator
TOP       ?= frontend_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/fetcher.sv */
`timescale 1ns/10ps
`include "frontend_config.svh"

module fetcher (
    input  logic                     clk,
    input  logic                     rst,
    output logic                     mem_rd,
    output logic [`FE_ADDR_W-1:0]    mem_addr,
    input  logic                     mem_valid,
    input  logic [31:0]              mem_data,
    input  logic                     iq_full,
    output logic                     iq_push,
    output frontend_pkg::iq_entry_t  push_entry,
    input  logic                     redirect,
    input  logic [`FE_ADDR_W-1:0]    redirect_pc,
    input  logic                     commit_en,
    input  logic                     commit_taken,
    input  logic [`FE_ADDR_W-1:0]    commit_pc
);

    logic [`FE_ADDR_W-1:0]  pc;
    logic                   pending;
    logic                   stale;
    logic                   fetch_en;
    frontend_pkg::rv_inst_u query_inst;
    logic                   pred_taken;
    logic [`FE_ADDR_W-1:0]  pred_offset;
    logic [`FE_ADDR_W-1:0]  next_pc;

    // returned word goes straight to the predictor
    assign query_inst = mem_data;

    predictor u_predictor (
        .clk          (clk),
        .rst          (rst),
        .query_pc     (pc),
        .query_inst   (query_inst),
        .pred_taken   (pred_taken),
        .pred_offset  (pred_offset),
        .commit_en    (commit_en),
        .commit_taken (commit_taken),
        .commit_pc    (commit_pc)
    );

    // pc stays on the outstanding read until its response arrives
    assign next_pc = pred_taken ? (pc + pred_offset) : (pc + `FE_ADDR_W'(4));

    // one read at a time, only with a free queue slot
    // a redirect this cycle moves the pc first
    assign mem_rd   = fetch_en && !pending && !iq_full && !redirect;
    assign mem_addr = pc;

    // stale responses and responses hit by a redirect are dropped
    assign iq_push = mem_valid && !stale && !redirect;

    always_comb begin
        push_entry.pc         = pc;
        push_entry.inst       = mem_data;
        push_entry.pred_taken = pred_taken;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= `FE_RESET_PC;
            pending  <= 1'b0;
            stale    <= 1'b0;
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;

            // mem_rd needs !pending and mem_valid needs pending, never both
            if (mem_rd) begin
                pending <= 1'b1;
            end else if (mem_valid) begin
                pending <= 1'b0;
            end

            if (redirect) begin
                pc <= redirect_pc;
                // a read still in flight must not be pushed later
                stale <= pending && !mem_valid;
            end else if (mem_valid) begin
                stale <= 1'b0;
                if (!stale) begin
                    pc <= next_pc;
                end
            end
        end
    end

endmodule

/* logic/frontend_config.svh */
`ifndef FRONTEND_CONFIG_SVH
`define FRONTEND_CONFIG_SVH

// width of every fetch address and pc
`define FE_ADDR_W 32

// counter table index width
// the index comes from pc bits FE_BHT_IDX_W+1 down to 2
`define FE_BHT_IDX_W 8

// instruction queue depth, must be a power of two
`define FE_IQ_DEPTH 4

// first fetch address after reset
`define FE_RESET_PC 32'h0000_0000

`endif

/* logic/frontend_pkg.sv */
`include "frontend_config.svh"

package frontend_pkg;

    // rv32i major opcodes the predictor cares about
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // j-format view of an instruction word
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // b-format view of the same word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef union packed {
        j_fmt_t j;
        b_fmt_t b;
    } rv_inst_u;

    // 2-bit saturating counter, upper bit is the taken prediction
    typedef enum logic [1:0] {
        BHT_STRONG_NT = 2'd0,
        BHT_WEAK_NT   = 2'd1,
        BHT_WEAK_T    = 2'd2,
        BHT_STRONG_T  = 2'd3
    } bht_state_e;

    // one fetched instruction as it sits in the queue
    typedef struct packed {
        logic [`FE_ADDR_W-1:0] pc;
        logic [31:0]           inst;
        logic                  pred_taken;
    } iq_entry_t;

endpackage

/* logic/frontend_top.sv */
`timescale 1ns/10ps
`include "frontend_config.svh"

module frontend_top (
    input  logic                    clk,
    input  logic                    rst,
    // instruction memory
    output logic                    mem_rd,
    output logic [`FE_ADDR_W-1:0]   mem_addr,
    input  logic                    mem_valid,
    input  logic [31:0]             mem_data,
    // issue side
    output logic                    iq_valid,
    output frontend_pkg::iq_entry_t iq_entry,
    input  logic                    iq_pop,
    // counter training from the rob
    input  logic                    commit_en,
    input  logic                    commit_taken,
    input  logic [`FE_ADDR_W-1:0]   commit_pc,
    // misprediction recovery
    input  logic                    redirect,
    input  logic [`FE_ADDR_W-1:0]   redirect_pc
);

    logic                    iq_full;
    logic                    iq_push;
    frontend_pkg::iq_entry_t push_entry;

    fetcher u_fetcher (
        .clk          (clk),
        .rst          (rst),
        .mem_rd       (mem_rd),
        .mem_addr     (mem_addr),
        .mem_valid    (mem_valid),
        .mem_data     (mem_data),
        .iq_full      (iq_full),
        .iq_push      (iq_push),
        .push_entry   (push_entry),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .commit_en    (commit_en),
        .commit_taken (commit_taken),
        .commit_pc    (commit_pc)
    );

    // redirect also flushes everything already queued
    inst_queue u_inst_queue (
        .clk        (clk),
        .rst        (rst),
        .push       (iq_push),
        .push_entry (push_entry),
        .full       (iq_full),
        .flush      (redirect),
        .pop        (iq_pop),
        .head_valid (iq_valid),
        .head_entry (iq_entry)
    );

endmodule

/* logic/inst_queue.sv */
`timescale 1ns/10ps
`include "frontend_config.svh"

module inst_queue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    push,
    input  frontend_pkg::iq_entry_t push_entry,
    output logic                    full,
    input  logic                    flush,
    input  logic                    pop,
    output logic                    head_valid,
    output frontend_pkg::iq_entry_t head_entry
);

    localparam int DEPTH = `FE_IQ_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    frontend_pkg::iq_entry_t entries [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign full       = (count == (PTR_W+1)'(DEPTH));
    assign head_valid = (count != '0);

    // first word falls through
    assign head_entry = entries[rd_ptr];

    // pop on empty is ignored, push on full cannot happen by design
    assign do_push = push && !full;
    assign do_pop  = pop && head_valid;

    // storage, no reset
    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* logic/predictor.sv */
`timescale 1ns/10ps
`include "frontend_config.svh"

module predictor (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`FE_ADDR_W-1:0]  query_pc,
    input  frontend_pkg::rv_inst_u query_inst,
    output logic                   pred_taken,
    output logic [`FE_ADDR_W-1:0]  pred_offset,
    input  logic                   commit_en,
    input  logic                   commit_taken,
    input  logic [`FE_ADDR_W-1:0]  commit_pc
);

    localparam int BHT_SIZE = 1 << `FE_BHT_IDX_W;

    frontend_pkg::bht_state_e bht [BHT_SIZE];

    logic [`FE_BHT_IDX_W-1:0] query_idx;
    logic [`FE_BHT_IDX_W-1:0] commit_idx;
    frontend_pkg::bht_state_e cur_state;
    frontend_pkg::bht_state_e next_state;
    logic [20:0]              j_imm;
    logic [12:0]              b_imm;

    // table index from the word address
    assign query_idx  = query_pc[`FE_BHT_IDX_W+1:2];
    assign commit_idx = commit_pc[`FE_BHT_IDX_W+1:2];

    // both immediates read from the same word
    assign j_imm = {query_inst.j.imm20, query_inst.j.imm19_12, query_inst.j.imm11,
                    query_inst.j.imm10_1, 1'b0};
    assign b_imm = {query_inst.b.imm12, query_inst.b.imm11, query_inst.b.imm10_5,
                    query_inst.b.imm4_1, 1'b0};

    // taken decision and offset
    always_comb begin
        pred_taken  = 1'b0;
        pred_offset = {{(`FE_ADDR_W-13){b_imm[12]}}, b_imm};
        case (query_inst.j.opcode)
            frontend_pkg::OPC_JAL: begin
                pred_taken  = 1'b1;
                pred_offset = {{(`FE_ADDR_W-21){j_imm[20]}}, j_imm};
            end
            frontend_pkg::OPC_BRANCH: begin
                pred_taken = bht[query_idx][1];
            end
            // jalr and every other opcode stay not taken
            default: begin
                pred_taken = 1'b0;
            end
        endcase
    end

    // saturating step for the committed branch
    always_comb begin
        cur_state  = bht[commit_idx];
        next_state = cur_state;
        if (commit_taken) begin
            if (cur_state != frontend_pkg::BHT_STRONG_T) begin
                next_state = frontend_pkg::bht_state_e'(cur_state + 2'd1);
            end
        end else begin
            if (cur_state != frontend_pkg::BHT_STRONG_NT) begin
                next_state = frontend_pkg::bht_state_e'(cur_state - 2'd1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BHT_SIZE; i++) begin
                bht[i] <= frontend_pkg::BHT_WEAK_NT;
            end
        end else if (commit_en) begin
            bht[commit_idx] <= next_state;
        end
    end

endmodule

/* sim/frontend_tb.sv */
`timescale 1ns/10ps
`include "frontend_config.svh"

module frontend_tb;

    localparam int PROG_WORDS = 32;
    localparam int DEPTH      = `FE_IQ_DEPTH;
    localparam int WAIT_LIMIT = 400;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    mem_rd;
    logic [`FE_ADDR_W-1:0]   mem_addr;
    logic                    mem_valid;
    logic [31:0]             mem_data;
    logic                    iq_valid;
    frontend_pkg::iq_entry_t iq_entry;
    logic                    iq_pop;
    logic                    commit_en;
    logic                    commit_taken;
    logic [`FE_ADDR_W-1:0]   commit_pc;
    logic                    redirect;
    logic [`FE_ADDR_W-1:0]   redirect_pc;

    logic [31:0] prog [PROG_WORDS];
    logic [31:0] lfsr_state = 32'd78038;
    int          pop_mode = 0;

    // memory model state
    logic        mem_busy;
    int          mem_wait;
    logic [31:0] mem_rd_addr;

    // reference model state
    logic [1:0]              ref_bht [1 << `FE_BHT_IDX_W];
    frontend_pkg::iq_entry_t exp_q [$];
    logic [31:0]             exp_pc;
    logic                    ref_pend;
    logic                    ref_stale;
    int                      push_count = 0;
    int                      pop_count = 0;

    frontend_top UUT (.*);

    always #5 clk = ~clk;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
    endtask

    function automatic logic [31:0] enc_jal(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, frontend_pkg::OPC_JAL};
    endfunction

    function automatic logic [31:0] enc_branch(input logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11],
                frontend_pkg::OPC_BRANCH};
    endfunction

    // immediates straight from the rv32i bit layout
    function automatic logic [31:0] j_offset(input logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    function automatic logic [31:0] b_offset(input logic [31:0] w);
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic logic [1:0] bht_step(input logic [1:0] c, input logic taken);
        if (taken) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    task automatic load_program();
        // addi x1, x0, <byte address>
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = {12'(i * 4), 5'd0, 3'b000, 5'd1, 7'b0010011};
        end
        prog[1]  = enc_branch(13'd8);
        prog[2]  = enc_jal(21'd8);
        prog[5]  = {12'd0, 5'd1, 3'b000, 5'd0, frontend_pkg::OPC_JALR};
        prog[7]  = enc_branch(13'd12);
        prog[9]  = enc_jal(21'd12);
        prog[14] = {12'd0, 5'd1, 3'b000, 5'd0, frontend_pkg::OPC_JALR};
        prog[17] = enc_branch(13'd16);
        prog[20] = enc_jal(21'd8);
        prog[25] = enc_branch(13'd8);
        prog[28] = enc_jal(21'd8);
        // wrap back to the start
        prog[31] = enc_jal(21'(-124));
    endtask

    // memory with 1 to 3 cycles of latency and the pop driver
    always @(posedge clk) begin
        int lat;
        int pop_bit;
        mem_valid <= 1'b0;
        if (rst) begin
            mem_busy = 1'b0;
            iq_pop <= 1'b0;
        end else begin
            if (mem_rd) begin
                assert (!mem_busy) else stop_on_error(
                    "second read issued while one is outstanding");
                assert (mem_addr < PROG_WORDS * 4) else stop_on_error("fetch left the program");
                take_bits(2, lat);
                mem_busy = 1'b1;
                mem_wait = lat % 3;
                mem_rd_addr = mem_addr;
            end
            if (mem_busy) begin
                if (mem_wait == 0) begin
                    mem_valid <= 1'b1;
                    mem_data  <= prog[mem_rd_addr[6:2]];
                    mem_busy = 1'b0;
                end else begin
                    mem_wait--;
                end
            end
            take_bits(1, pop_bit);
            iq_pop <= (pop_mode == 1) ? pop_bit[0] : 1'b0;
        end
    end

    // reference model and checks
    always @(posedge clk) begin
        logic                    taken;
        logic [31:0]             off;
        frontend_pkg::iq_entry_t ent;
        if (rst) begin
            exp_q.delete();
            exp_pc    = `FE_RESET_PC;
            ref_pend  = 1'b0;
            ref_stale = 1'b0;
            for (int i = 0; i < (1 << `FE_BHT_IDX_W); i++) begin
                ref_bht[i] = 2'd1;
            end
        end else begin
            assert (iq_valid == (exp_q.size() != 0)) else stop_on_error($sformatf(
                "** Error: iq_valid = 0x%h, expected 0x%h", iq_valid, exp_q.size() != 0));
            if (mem_rd) begin
                assert (exp_q.size() < DEPTH) else stop_on_error("read issued with a full queue");
                assert (mem_addr == exp_pc) else stop_on_error($sformatf(
                    "** Error: mem_addr = 0x%h, expected 0x%h", mem_addr, exp_pc));
            end
            // a pop in a redirect cycle is lost to the flush
            if (iq_pop && iq_valid && !redirect) begin
                ent = exp_q.pop_front();
                assert (iq_entry.pc == ent.pc) else stop_on_error($sformatf(
                    "** Error: iq_entry.pc = 0x%h, expected 0x%h", iq_entry.pc, ent.pc));
                assert (iq_entry.inst == ent.inst) else stop_on_error($sformatf(
                    "** Error: iq_entry.inst = 0x%h, expected 0x%h", iq_entry.inst, ent.inst));
                assert (iq_entry.pred_taken == ent.pred_taken) else stop_on_error($sformatf(
                    "** Error: iq_entry.pred_taken = 0x%h, expected 0x%h",
                    iq_entry.pred_taken, ent.pred_taken));
                pop_count++;
            end
            if (mem_valid) begin
                if (!redirect && !ref_stale) begin
                    taken = 1'b0;
                    off   = b_offset(mem_data);
                    if (mem_data[6:0] == frontend_pkg::OPC_JAL) begin
                        taken = 1'b1;
                        off   = j_offset(mem_data);
                    end else if (mem_data[6:0] == frontend_pkg::OPC_BRANCH) begin
                        taken = ref_bht[exp_pc[`FE_BHT_IDX_W+1:2]][1];
                    end
                    ent.pc         = exp_pc;
                    ent.inst       = mem_data;
                    ent.pred_taken = taken;
                    exp_q.push_back(ent);
                    exp_pc = taken ? exp_pc + off : exp_pc + 32'd4;
                    push_count++;
                end
                ref_pend  = 1'b0;
                ref_stale = 1'b0;
            end
            if (redirect) begin
                ref_stale = ref_pend;
                exp_pc    = redirect_pc;
                exp_q.delete();
            end
            if (mem_rd) begin
                ref_pend = 1'b1;
            end
            if (commit_en) begin
                ref_bht[commit_pc[`FE_BHT_IDX_W+1:2]] =
                    bht_step(ref_bht[commit_pc[`FE_BHT_IDX_W+1:2]], commit_taken);
            end
        end
    end

    task automatic set_pops(input int mode);
        @(negedge clk);
        pop_mode = mode;
    endtask

    task automatic wait_pops(input int n);
        int target;
        int cycles;
        target = pop_count + n;
        cycles = 0;
        while (pop_count < target) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) stop_on_error("timeout waiting for entries to be popped");
        end
    endtask

    task automatic wait_full();
        int cycles;
        cycles = 0;
        while (!(exp_q.size() == DEPTH && !ref_pend)) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) stop_on_error("timeout waiting for the queue to fill");
        end
    endtask

    // late picks a response that comes after the next cycle
    task automatic wait_read(input logic late);
        int cycles;
        cycles = 0;
        while (!(ref_pend && !mem_valid && ((mem_wait != 0) == late))) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) stop_on_error("timeout waiting for a read in flight");
        end
    endtask

    task automatic commit_pulse(input logic [31:0] pc, input logic taken);
        @(posedge clk);
        commit_en    <= 1'b1;
        commit_pc    <= pc;
        commit_taken <= taken;
        @(posedge clk);
        commit_en <= 1'b0;
    endtask

    task automatic redirect_to(input logic [31:0] pc);
        @(posedge clk);
        redirect    <= 1'b1;
        redirect_pc <= pc;
        @(posedge clk);
        redirect <= 1'b0;
    endtask

    initial begin
        rst          = 1'b1;
        iq_pop       = 1'b0;
        commit_en    = 1'b0;
        commit_taken = 1'b0;
        commit_pc    = '0;
        redirect     = 1'b0;
        redirect_pc  = '0;
        mem_valid    = 1'b0;
        mem_data     = '0;
        load_program();
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // untrained run through the program
        set_pops(1);
        wait_pops(40);

        // train the branch at pc 4 up to taken and refetch it
        commit_pulse(32'h4, 1'b1);
        commit_pulse(32'h4, 1'b1);
        redirect_to(32'h0);
        wait_pops(8);
        commit_pulse(32'h4, 1'b1);
        for (int i = 0; i < 3; i++) begin
            commit_pulse(32'h4, 1'b0);
            redirect_to(32'h0);
            wait_pops(6);
        end

        // back-pressure and then resume popping
        set_pops(0);
        wait_full();
        repeat (12) @(negedge clk);
        set_pops(1);
        wait_pops(12);

        // redirect with no read in flight
        set_pops(0);
        wait_full();
        redirect_to(32'h40);
        set_pops(1);
        wait_pops(10);

        // redirect with a read in flight, response with it or after it
        for (int i = 0; i < 4; i++) begin
            wait_read(i % 2 == 1);
            redirect_to((i % 2 == 0) ? 32'h0 : 32'h40);
            wait_pops(5);
        end

        @(negedge clk);
        $display("Done: no errors");
        $finish;
    end

endmodule

/* src.f */
+incdir+logic
logic/frontend_pkg.sv
logic/predictor.sv
logic/fetcher.sv
logic/inst_queue.sv
logic/frontend_top.sv
sim/frontend_tb.sv
